// ==== design/smc_bus_pkg.sv ====
// Host-side types of the static memory controller
// Request and response words passed with the single-cycle host strobe
package smc_bus_pkg;

   // Transfer size, log2 of the byte count
   typedef enum logic [1:0]
   {
      XSIZ_8  = 2'd0,
      XSIZ_16 = 2'd1,
      XSIZ_32 = 2'd2
   } xfer_size_t;

   // ----------------------------
   // Host request, valid with the strobe only
   typedef struct packed
   {
      logic [31:0] addr;
      logic        write;          // 1 write, 0 read
      xfer_size_t  xfer_size;
      logic [31:0] wdata;          // Byte for offset k on lane k
   } host_req_t;

   // Host response, valid with rsp_valid
   typedef struct packed
   {
      logic [31:0] rdata;          // Lane aligned, unused lanes zero
      logic        error;          // Address hit no bank
   } host_rsp_t;

endpackage

// ==== design/smc_emi_pkg.sv ====
// Memory-side definitions of the static memory controller
// Bank table, access timing, FSM states and the external interface word
package smc_emi_pkg;

   // Bank data width, log2 of the byte count
   typedef enum logic [1:0]
   {
      BSIZ_8  = 2'd0,
      BSIZ_16 = 2'd1,
      BSIZ_32 = 2'd2
   } bus_size_t;

   // ----------------------------
   // Bank table, address bits 31:28 pick the bank
   localparam int NUM_BANKS = 3;

   localparam logic [31:0] BANK_BASE [NUM_BANKS] =
      '{32'h0000_0000, 32'h1000_0000, 32'h2000_0000};
   localparam logic [31:0] BANK_MASK [NUM_BANKS] =
      '{32'hF000_0000, 32'hF000_0000, 32'hF000_0000};
   localparam bus_size_t   BANK_BUS_SIZE [NUM_BANKS] =
      '{BSIZ_32, BSIZ_16, BSIZ_8};

   // Read/write cycles held by every external access
   localparam int ACCESS_CYCLES = 2;

   // Controller FSM states
   typedef enum logic [1:0]
   {
      SMC_IDLE = 2'd0,
      SMC_RW   = 2'd1,
      SMC_DONE = 2'd2
   } smc_state_t;

   // ----------------------------
   // External interface outputs, all strobes active low
   typedef struct packed
   {
      logic [31:0]          addr;
      logic [NUM_BANKS-1:0] n_cs;
      logic [3:0]           n_be;
      logic                 n_we;
      logic                 n_oe;
      logic [31:0]          wdata;
   } emi_out_t;

endpackage

// ==== design/smc_access_decode.sv ====
// Request decode for the static memory controller
// Bank match, bus size and access count, live on the strobe and held after it
`timescale 1ns/1ps

module smc_access_decode
(
   input  logic                                 sys_clk30,
   input  logic                                 n_sys_reset30,
   input  logic                                 valid_access,  // Host strobe
   input  smc_bus_pkg::host_req_t               req,
   output logic [smc_emi_pkg::NUM_BANKS-1:0]    v_cs,          // One-hot bank
   output smc_emi_pkg::bus_size_t               v_bus_size,
   output smc_bus_pkg::xfer_size_t              v_xfer_size,
   output logic [1:0]                           num_access,    // Accesses minus one
   output logic                                 addr_miss      // No bank hit
);

   typedef struct packed
   {
      logic [smc_emi_pkg::NUM_BANKS-1:0] cs;
      smc_emi_pkg::bus_size_t            bus_size;
      smc_bus_pkg::xfer_size_t           xfer_size;
      logic [1:0]                        num_access;
      logic                              miss;
   } decode_t;

   decode_t live_dec;   // From the request on the bus
   decode_t r_dec;      // Held for the rest of the transfer
   decode_t v_dec;      // Validated

   always_comb
   begin
      logic [1:0] span;  // log2(xfer bytes / bus bytes)
      live_dec.cs       = '0;
      live_dec.bus_size = smc_emi_pkg::BSIZ_32;        // Don't care on a miss
      for (int i = 0; i < smc_emi_pkg::NUM_BANKS; i++)
      begin
         if ((req.addr & smc_emi_pkg::BANK_MASK[i]) == smc_emi_pkg::BANK_BASE[i])
         begin
            live_dec.cs[i]    = 1'b1;
            live_dec.bus_size = smc_emi_pkg::BANK_BUS_SIZE[i];
         end
      end
      live_dec.xfer_size = req.xfer_size;
      live_dec.miss      = ~|live_dec.cs;
      span = 2'(req.xfer_size) - 2'(live_dec.bus_size);
      // Span 1 -> 1 extra access, span 2 -> 3 extra
      if (2'(req.xfer_size) > 2'(live_dec.bus_size))
         live_dec.num_access = {span[1], |span};
      else
         live_dec.num_access = 2'd0;                   // Fits in one access
   end

   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         r_dec <= '0;
      else if (valid_access)
         r_dec <= live_dec;                            // Hold till next strobe
   end

   assign v_dec       = valid_access ? live_dec : r_dec;   // Live in request cycle
   assign v_cs        = v_dec.cs;
   assign v_bus_size  = v_dec.bus_size;
   assign v_xfer_size = v_dec.xfer_size;
   assign num_access  = v_dec.num_access;
   assign addr_miss   = v_dec.miss;

endmodule

// ==== design/smc_state_machine.sv ====
// Transfer sequencer for the static memory controller
// Steps a request through its external accesses and flags completion
`timescale 1ns/1ps

module smc_state_machine
(
   input  logic                      sys_clk30,
   input  logic                      n_sys_reset30,
   input  logic                      valid_access,   // Host strobe
   input  logic [1:0]                num_access,     // Accesses minus one
   input  logic                      addr_miss,      // No bank hit
   output smc_emi_pkg::smc_state_t   smc_nextstate,
   output logic [1:0]                r_num_access,   // Accesses still to go
   output logic                      access_end,     // Last cycle of an access
   output logic                      smc_done,       // One cycle in done state
   output logic                      busy
);

   smc_emi_pkg::smc_state_t smc_state;
   logic [1:0]              wait_cnt;     // Cycles spent in this access

   assign access_end = (smc_state == smc_emi_pkg::SMC_RW) &&
                       (wait_cnt == 2'(smc_emi_pkg::ACCESS_CYCLES - 1));
   assign smc_done   = (smc_state == smc_emi_pkg::SMC_DONE);

   // ----------------------------
   // Next state
   always_comb
   begin
      smc_nextstate = smc_state;
      case (smc_state)
         smc_emi_pkg::SMC_IDLE:
         begin
            if (valid_access)
               smc_nextstate = addr_miss ? smc_emi_pkg::SMC_DONE : smc_emi_pkg::SMC_RW;
         end
         smc_emi_pkg::SMC_RW:
         begin
            if (access_end && (r_num_access == 2'd0))
               smc_nextstate = smc_emi_pkg::SMC_DONE;   // Last access over
         end
         default:
            smc_nextstate = smc_emi_pkg::SMC_IDLE;      // Done lasts one cycle
      endcase
   end

   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         smc_state <= smc_emi_pkg::SMC_IDLE;
      else
         smc_state <= smc_nextstate;
   end

   // ----------------------------
   // Wait and access counters
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         wait_cnt     <= 2'd0;
         r_num_access <= 2'd0;
      end
      else
      begin
         if (access_end || (smc_state != smc_emi_pkg::SMC_RW))
            wait_cnt <= 2'd0;                  // Restart for next access
         else
            wait_cnt <= wait_cnt + 2'd1;
         if (valid_access)
            r_num_access <= num_access;
         else if (access_end && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;
      end
   end

   // Busy through the response cycle
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         busy <= 1'b0;
      else
         busy <= (smc_nextstate != smc_emi_pkg::SMC_IDLE) || smc_done;
   end

   // No back-pressure, host must wait out busy
   a_no_strobe_busy: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
      busy |-> !valid_access);

endmodule

// ==== design/smc_addr_gen.sv ====
// External address, chip select and byte enable generation
// Loads the first access address on the strobe and steps bits 1:0 per access
`timescale 1ns/1ps

module smc_addr_gen
(
   input  logic                               sys_clk30,
   input  logic                               n_sys_reset30,
   input  logic                               valid_access,  // Host strobe
   input  logic [1:0]                         r_num_access,  // Accesses still to go
   input  smc_emi_pkg::bus_size_t             v_bus_size,
   input  smc_bus_pkg::xfer_size_t            v_xfer_size,
   input  logic [smc_emi_pkg::NUM_BANKS-1:0]  v_cs,          // Validated one-hot bank
   input  logic [31:0]                        addr,          // Host address
   input  logic                               smc_done,
   input  logic                               access_end,
   input  smc_emi_pkg::smc_state_t            smc_nextstate,
   output logic [31:0]                        smc_addr,      // External address
   output logic [3:0]                         smc_n_be,      // External byte enables
   output logic [smc_emi_pkg::NUM_BANKS-1:0]  smc_n_cs,      // External chip selects
   output logic [3:0]                         n_be           // Unregistered enables
);

   logic [smc_emi_pkg::NUM_BANKS-1:0] r_cs;     // Stored bank select
   logic [1:0]                        r_addr;   // Stored address bits 1:0
   logic [1:0]                        v_addr;   // Validated address bits 1:0
   logic                              rw_next;

   assign rw_next = (smc_nextstate == smc_emi_pkg::SMC_RW);
   assign v_addr  = valid_access ? addr[1:0] : r_addr;

   // ----------------------------
   // Stores
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         r_cs   <= '0;
         r_addr <= 2'd0;
      end
      else if (valid_access)
      begin
         r_cs   <= v_cs;
         r_addr <= addr[1:0];
      end
      else if (smc_done)
         r_cs <= '0;                           // Release bank at end of transfer
   end

   // ----------------------------
   // External address
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         smc_addr <= 32'h0;
      else if (valid_access)
      begin
         smc_addr[31:2] <= addr[31:2];
         case (v_xfer_size)                    // First access, aligned to transfer
            smc_bus_pkg::XSIZ_8:  smc_addr[1:0] <= addr[1:0];
            smc_bus_pkg::XSIZ_16: smc_addr[1:0] <= {addr[1], 1'b0};
            default:              smc_addr[1:0] <= 2'b00;
         endcase
      end
      else if (access_end && (r_num_access != 2'd0))
      begin
         case (v_bus_size)                     // Up by one bus width
            smc_emi_pkg::BSIZ_8:  smc_addr[1:0] <= smc_addr[1:0] + 2'd1;
            smc_emi_pkg::BSIZ_16: smc_addr[1:0] <= smc_addr[1:0] + 2'd2;
            default:              smc_addr[1:0] <= smc_addr[1:0];
         endcase
      end
   end

   // ----------------------------
   // Internal byte enables, little-endian
   always_comb
   begin
      if (|v_cs)
      begin
         casez ({v_xfer_size, v_bus_size, v_addr})
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_8,  2'b??}: n_be = 4'b1110;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_16, 2'b?0}: n_be = 4'b1110;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_16, 2'b?1}: n_be = 4'b1101;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_32, 2'b00}: n_be = 4'b1110;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_32, 2'b01}: n_be = 4'b1101;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_32, 2'b10}: n_be = 4'b1011;
            {smc_bus_pkg::XSIZ_8,  smc_emi_pkg::BSIZ_32, 2'b11}: n_be = 4'b0111;
            {smc_bus_pkg::XSIZ_16, smc_emi_pkg::BSIZ_8,  2'b??}: n_be = 4'b1110;
            {smc_bus_pkg::XSIZ_16, smc_emi_pkg::BSIZ_16, 2'b??}: n_be = 4'b1100;
            {smc_bus_pkg::XSIZ_16, smc_emi_pkg::BSIZ_32, 2'b0?}: n_be = 4'b1100;
            {smc_bus_pkg::XSIZ_16, smc_emi_pkg::BSIZ_32, 2'b1?}: n_be = 4'b0011;
            {smc_bus_pkg::XSIZ_32, smc_emi_pkg::BSIZ_8,  2'b??}: n_be = 4'b1110;
            {smc_bus_pkg::XSIZ_32, smc_emi_pkg::BSIZ_16, 2'b??}: n_be = 4'b1100;
            {smc_bus_pkg::XSIZ_32, smc_emi_pkg::BSIZ_32, 2'b??}: n_be = 4'b0000;
            default:                                             n_be = 4'b1111;
         endcase
      end
      else
         n_be = 4'b1111;                       // No bank, nothing enabled
   end

   // ----------------------------
   // Registered selects, only while accessing
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         smc_n_cs <= '1;
         smc_n_be <= 4'hF;
      end
      else if (rw_next)
      begin
         smc_n_cs <= ~(valid_access ? v_cs : r_cs);
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= '1;
         smc_n_be <= 4'hF;
      end
   end

   a_one_cs: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
      $onehot0(~smc_n_cs));
   a_be_with_cs: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
      !(&smc_n_cs) |-> (smc_n_be != 4'hF));

endmodule

// ==== design/smc_data_path.sv ====
// Write lane steering and read lane assembly for the memory controller
// Returns the host response one cycle after the last external access
`timescale 1ns/1ps

module smc_data_path
(
   input  logic                      sys_clk30,
   input  logic                      n_sys_reset30,
   input  smc_bus_pkg::host_req_t    req,
   input  logic                      valid_access,   // Host strobe
   input  smc_emi_pkg::bus_size_t    v_bus_size,
   input  logic [1:0]                smc_addr_lo,    // Current access offset
   input  logic                      access_end,
   input  logic                      smc_done,
   input  logic                      addr_miss,
   input  smc_emi_pkg::smc_state_t   smc_nextstate,
   input  logic [31:0]               emi_rdata,
   output logic [31:0]               emi_wdata,
   output logic                      n_we,
   output logic                      n_oe,
   output logic                      rsp_valid,
   output smc_bus_pkg::host_rsp_t    rsp
);

   logic [31:0] r_wdata;      // Write word from the strobe
   logic        r_write;
   logic [3:0]  lane_mask;    // Lanes of the host transfer
   logic [3:0]  r_mask;
   logic [31:0] byte_mask;
   logic [31:0] r_rdata;      // Read word being assembled
   logic        write_v;

   assign write_v = valid_access ? req.write : r_write;

   always_comb
   begin
      case (req.xfer_size)
         smc_bus_pkg::XSIZ_8:  lane_mask = 4'b0001 << req.addr[1:0];
         smc_bus_pkg::XSIZ_16: lane_mask = req.addr[1] ? 4'b1100 : 4'b0011;
         default:              lane_mask = 4'b1111;
      endcase
      for (int k = 0; k < 4; k++)
         byte_mask[8*k +: 8] = {8{r_mask[k]}};
   end

   always_ff @(posedge sys_clk30)
   begin
      if (valid_access)
      begin
         r_wdata <= req.wdata;
         r_mask  <= lane_mask;
      end
   end

   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         r_write <= 1'b0;
      else if (valid_access)
         r_write <= req.write;
   end

   // ----------------------------
   // Write steering, narrow banks take the addressed lanes low
   always_comb
   begin
      emi_wdata = r_wdata;
      case (v_bus_size)
         smc_emi_pkg::BSIZ_8:  emi_wdata[7:0]  = r_wdata[{smc_addr_lo, 3'b000} +: 8];
         smc_emi_pkg::BSIZ_16: emi_wdata[15:0] = r_wdata[{smc_addr_lo[1], 4'b0000} +: 16];
         default: ;
      endcase
   end

   // Strobes line up with the chip select
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         n_we <= 1'b1;
         n_oe <= 1'b1;
      end
      else
      begin
         n_we <= ~((smc_nextstate == smc_emi_pkg::SMC_RW) & write_v);
         n_oe <= ~((smc_nextstate == smc_emi_pkg::SMC_RW) & ~write_v);
      end
   end

   // ----------------------------
   // Read assembly, one capture per access end
   always_ff @(posedge sys_clk30)
   begin
      if (valid_access)
         r_rdata <= '0;
      else if (access_end && !r_write)
      begin
         case (v_bus_size)
            smc_emi_pkg::BSIZ_8:  r_rdata[{smc_addr_lo, 3'b000} +: 8]     <= emi_rdata[7:0];
            smc_emi_pkg::BSIZ_16: r_rdata[{smc_addr_lo[1], 4'b0000} +: 16] <= emi_rdata[15:0];
            default:              r_rdata <= emi_rdata;
         endcase
      end
   end

   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= smc_done;
   end

   always_ff @(posedge sys_clk30)
   begin
      if (smc_done)
      begin
         rsp.rdata <= r_rdata & byte_mask;    // Unused lanes zero
         rsp.error <= addr_miss;
      end
   end

endmodule

// ==== design/smc_lite_top.sv ====
// Top level of the light static memory controller
// Connects decode, FSM, address and data blocks and packs the external bus
`timescale 1ns/1ps

module smc_lite_top
(
   input  logic                      sys_clk30,
   input  logic                      n_sys_reset30,
   input  logic                      req_valid,     // One-cycle host strobe
   input  smc_bus_pkg::host_req_t    req,
   input  logic [31:0]               emi_rdata,     // Combinational from memory
   output logic                      busy,
   output logic                      rsp_valid,
   output smc_bus_pkg::host_rsp_t    rsp,
   output smc_emi_pkg::emi_out_t     emi
);

   logic [smc_emi_pkg::NUM_BANKS-1:0] v_cs;
   smc_emi_pkg::bus_size_t            v_bus_size;
   smc_bus_pkg::xfer_size_t           v_xfer_size;
   logic [1:0]                        num_access;
   logic                              addr_miss;
   smc_emi_pkg::smc_state_t           smc_nextstate;
   logic [1:0]                        r_num_access;
   logic                              access_end;
   logic                              smc_done;
   logic [31:0]                       smc_addr;
   logic [3:0]                        smc_n_be;
   logic [smc_emi_pkg::NUM_BANKS-1:0] smc_n_cs;
   logic [31:0]                       emi_wdata;
   logic                              n_we;
   logic                              n_oe;

   smc_access_decode u_decode
   (
      .sys_clk30, .n_sys_reset30, .valid_access (req_valid), .req,
      .v_cs, .v_bus_size, .v_xfer_size, .num_access, .addr_miss
   );

   smc_state_machine u_fsm
   (
      .sys_clk30, .n_sys_reset30, .valid_access (req_valid), .num_access, .addr_miss,
      .smc_nextstate, .r_num_access, .access_end, .smc_done, .busy
   );

   smc_addr_gen u_addr
   (
      .sys_clk30, .n_sys_reset30, .valid_access (req_valid), .r_num_access,
      .v_bus_size, .v_xfer_size, .v_cs, .addr (req.addr), .smc_done, .access_end,
      .smc_nextstate, .smc_addr, .smc_n_be, .smc_n_cs,
      .n_be ()                                          // Per-lane strobes unused here
   );

   smc_data_path u_data
   (
      .sys_clk30, .n_sys_reset30, .req, .valid_access (req_valid), .v_bus_size,
      .smc_addr_lo (smc_addr[1:0]), .access_end, .smc_done, .addr_miss,
      .smc_nextstate, .emi_rdata, .emi_wdata, .n_we, .n_oe, .rsp_valid, .rsp
   );

   // External bus word
   assign emi = '{addr: smc_addr, n_cs: smc_n_cs, n_be: smc_n_be,
                  n_we: n_we, n_oe: n_oe, wdata: emi_wdata};

endmodule

// ==== testbench/emi_memory_model.sv ====
// Byte-wide memory per bank behind the external interface of the controller
// Reads combinationally, writes enabled lanes, logs every access it sees
`timescale 1ns/1ps

module emi_memory_model
(
   input  logic                    sys_clk30,
   input  logic                    n_sys_reset30,
   input  smc_emi_pkg::emi_out_t   emi,
   output logic [31:0]             emi_rdata
);

   logic [7:0] mem [smc_emi_pkg::NUM_BANKS][256];   // Indexed by addr[7:0]
   int         sel_bank;                            // -1 with no select low
   int         sel_count;                           // Selects low this cycle
   int         phase;                               // Cycle within the access

   // Access log, read by the testbench
   logic [31:0] log_addr [256];
   logic [3:0]  log_be   [256];
   logic [1:0]  log_rw   [256];                     // {n_we, n_oe}
   logic [1:0]  log_bank [256];
   int          log_count;
   int          cs_cycles;                          // Cycles with one select low
   logic        multi_cs;                           // Sticky, two or more low

   initial
   begin
      for (int b = 0; b < smc_emi_pkg::NUM_BANKS; b++)
         for (int i = 0; i < 256; i++)
            mem[b][i] = 8'h00;
   end

   always_comb
   begin
      sel_bank  = -1;
      sel_count = 0;
      for (int b = 0; b < smc_emi_pkg::NUM_BANKS; b++)
      begin
         if (!emi.n_cs[b])
         begin
            sel_bank  = b;
            sel_count = sel_count + 1;
         end
      end
   end

   // ----------------------------
   // Read data, narrow banks return on the low lanes
   always_comb
   begin
      emi_rdata = 32'h0;
      case (sel_bank)
         0: for (int k = 0; k < 4; k++)
               emi_rdata[8*k +: 8] = mem[0][{emi.addr[7:2], 2'(k)}];
         1: for (int k = 0; k < 2; k++)
               emi_rdata[8*k +: 8] = mem[1][{emi.addr[7:1], 1'(k)}];
         2: emi_rdata[7:0] = mem[2][emi.addr[7:0]];
         default: ;                                 // Bus idle
      endcase
   end

   // ----------------------------
   // Writes and access log
   always @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         phase     <= 0;
         log_count <= 0;
         cs_cycles <= 0;
         multi_cs  <= 1'b0;
      end
      else
      begin
         if (sel_count > 1)
            multi_cs <= 1'b1;                       // Bus conflict
         if (sel_count == 1)
         begin
            cs_cycles <= cs_cycles + 1;
            if (!emi.n_we)
            begin
               case (sel_bank)
                  0: for (int k = 0; k < 4; k++)
                        if (!emi.n_be[k])
                           mem[0][{emi.addr[7:2], 2'(k)}] <= emi.wdata[8*k +: 8];
                  1: for (int k = 0; k < 2; k++)
                        if (!emi.n_be[k])
                           mem[1][{emi.addr[7:1], 1'(k)}] <= emi.wdata[8*k +: 8];
                  default: if (!emi.n_be[0])
                              mem[2][emi.addr[7:0]] <= emi.wdata[7:0];
               endcase
            end
            if (phase == smc_emi_pkg::ACCESS_CYCLES - 1)
            begin
               if (log_count < 256)
               begin
                  log_addr[log_count] <= emi.addr;
                  log_be[log_count]   <= emi.n_be;
                  log_rw[log_count]   <= {emi.n_we, emi.n_oe};
                  log_bank[log_count] <= 2'(sel_bank);
                  log_count           <= log_count + 1;
               end
               phase <= 0;                          // Next access starts
            end
            else
               phase <= phase + 1;
         end
         else
            phase <= 0;
      end
   end

endmodule

// ==== testbench/smc_lite_tb.sv ====
// Testbench for the light static memory controller
// Applies a table of host transfers and checks responses and external accesses
`timescale 1ns/1ps

module smc_lite_tb;

   localparam int MAX_ROWS       = 32;
   localparam int TIMEOUT_CYCLES = 200;

   typedef struct packed
   {
      logic                    write;
      logic [31:0]             addr;
      smc_bus_pkg::xfer_size_t size;
      logic [31:0]             wdata;
      logic [31:0]             exp_rdata;   // Lane aligned, unused lanes zero
      logic                    exp_error;
      logic [2:0]              exp_count;   // External accesses
   } row_t;

   logic                    sys_clk30;
   logic                    n_sys_reset30;
   logic                    req_valid;
   smc_bus_pkg::host_req_t  req;
   logic [31:0]             emi_rdata;
   logic                    busy;
   logic                    rsp_valid;
   smc_bus_pkg::host_rsp_t  rsp;
   smc_emi_pkg::emi_out_t   emi;

   row_t       rows [MAX_ROWS];
   int         row_count;
   logic [7:0] shadow [smc_emi_pkg::NUM_BANKS][256];   // Expected memory contents
   logic [15:0] lfsr_state;

   smc_lite_top DUT
   (
      .sys_clk30, .n_sys_reset30, .req_valid, .req, .emi_rdata,
      .busy, .rsp_valid, .rsp, .emi
   );

   emi_memory_model u_mem
   (
      .sys_clk30, .n_sys_reset30, .emi, .emi_rdata
   );

   initial
   begin
      sys_clk30 = 1'b0;
      forever #50 sys_clk30 = ~sys_clk30;               // 100 ns period
   end

   // ----------------------------
   // Reference rules
   function automatic int bank_of(input logic [31:0] addr);
      if (addr[31:28] < smc_emi_pkg::NUM_BANKS)
         return int'(addr[31:28]);
      return -1;                                        // Hits no bank
   endfunction

   function automatic int bus_bytes(input int bank);
      case (bank)
         0:       return 4;
         1:       return 2;
         default: return 1;
      endcase
   endfunction

   function automatic int xfer_bytes(input smc_bus_pkg::xfer_size_t size);
      return 1 << int'(size);
   endfunction

   // Little-endian lanes of one access, from the host address
   function automatic logic [3:0] expected_be(input int bank, input int xb,
                                              input logic [31:0] addr);
      int bb;
      int n;
      int off;
      bb  = bus_bytes(bank);
      n   = (xb < bb) ? xb : bb;
      off = (int'(addr[1:0]) % bb) & ~(n - 1);
      return ~(4'((1 << n) - 1) << off);
   endfunction

   // Galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   function logic [31:0] random_word();
      logic [31:0] w;
      w = 32'h0;
      for (int i = 0; i < 32; i++)
      begin
         w          = {w[30:0], lfsr_state[0]};        // One step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
      return w;
   endfunction

   // ----------------------------
   // Table building, shadow memory gives expected read data
   task automatic add_row(input logic write, input logic [31:0] addr,
                          input smc_bus_pkg::xfer_size_t size,
                          input logic [31:0] wdata, input logic use_rand);
      row_t row;
      int   bank;
      int   xb;
      int   first;
      int   idx;
      row       = '0;
      bank      = bank_of(addr);
      xb        = xfer_bytes(size);
      row.write = write;
      row.addr  = addr;
      row.size  = size;
      row.wdata = use_rand ? random_word() : wdata;
      if (bank < 0)
         row.exp_error = 1'b1;                          // No access at all
      else
      begin
         row.exp_count = (xb > bus_bytes(bank)) ? 3'(xb / bus_bytes(bank)) : 3'd1;
         first = int'(addr[1:0]) & ~(xb - 1);
         for (int k = first; k < first + xb; k++)
         begin
            idx = int'(addr[7:0] & 8'hFC) + k;
            if (write)
               shadow[bank][idx] = row.wdata[8*k +: 8];
            else
               row.exp_rdata[8*k +: 8] = shadow[bank][idx];
         end
      end
      rows[row_count] = row;
      row_count++;
   endtask

   // ----------------------------
   // Run helpers
   task step_cycle();
      @(posedge sys_clk30);
      #10;                                              // Drive and sample point
   endtask

   task abort_run(input string why);
      $display("%s at %0t", why, $time);
      $display("Regression failed");
      $fatal(1);
   endtask

   task check_value(input string name, input logic [31:0] actual,
                    input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("[FAIL] t=%0t %s actual=0x%0h expected=0x%0h",
                  $time, name, actual, expected);
         abort_run("Value mismatch");
      end
   endtask

   task automatic run_row(input int r);
      row_t row;
      int   base_log;
      int   base_cyc;
      int   waited;
      int   bank;
      int   first;
      row      = rows[r];
      bank     = bank_of(row.addr);
      check_value("busy", busy, 32'h0);
      base_log = u_mem.log_count;
      base_cyc = u_mem.cs_cycles;
      req_valid     = 1'b1;                             // Single-cycle strobe
      req.addr      = row.addr;
      req.write     = row.write;
      req.xfer_size = row.size;
      req.wdata     = row.wdata;
      step_cycle();
      req_valid = 1'b0;
      req       = '0;
      check_value("busy", busy, 32'h1);                 // Raised after the strobe
      for (waited = 0; (waited < TIMEOUT_CYCLES) && !rsp_valid; waited++)
         step_cycle();
      if (!rsp_valid)
         abort_run($sformatf("No response on row %0d within the timeout", r));
      check_value("busy", busy, 32'h1);                 // Held through the response
      check_value("rsp.error", rsp.error, row.exp_error);
      check_value("rsp.rdata", rsp.rdata, row.exp_rdata);
      check_value("access count", u_mem.log_count - base_log, row.exp_count);
      check_value("cs low cycles", u_mem.cs_cycles - base_cyc,
                  row.exp_count * smc_emi_pkg::ACCESS_CYCLES);
      check_value("two chip selects low", u_mem.multi_cs, 32'h0);
      first = int'(row.addr[1:0]) & ~(xfer_bytes(row.size) - 1);
      for (int i = 0; i < int'(row.exp_count); i++)
      begin
         check_value("emi.addr", u_mem.log_addr[base_log + i],
                     {row.addr[31:2], 2'((first + i * bus_bytes(bank)) % 4)});
         check_value("emi.n_be", u_mem.log_be[base_log + i],
                     expected_be(bank, xfer_bytes(row.size), row.addr));
         check_value("{emi.n_we, emi.n_oe}", u_mem.log_rw[base_log + i],
                     row.write ? 32'h1 : 32'h2);
         check_value("selected bank", u_mem.log_bank[base_log + i], bank);
      end
      step_cycle();
      check_value("rsp_valid", rsp_valid, 32'h0);        // One-cycle strobe
   endtask

   // ----------------------------
   // Main sequence
   initial
   begin
      n_sys_reset30 = 1'b0;
      req_valid     = 1'b0;
      req           = '0;
      row_count     = 0;
      lfsr_state    = 16'd68;
      for (int b = 0; b < smc_emi_pkg::NUM_BANKS; b++)
         for (int i = 0; i < 256; i++)
            shadow[b][i] = 8'h00;

      // Bank 0, 32-bit bus
      add_row(1'b1, 32'h0000_0010, smc_bus_pkg::XSIZ_32, 32'h0403_0201, 1'b0);
      add_row(1'b0, 32'h0000_0010, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      add_row(1'b1, 32'h0000_0020, smc_bus_pkg::XSIZ_8,  32'h0000_00A5, 1'b0);
      add_row(1'b1, 32'h0000_0021, smc_bus_pkg::XSIZ_8,  32'h0, 1'b1);
      add_row(1'b1, 32'h0000_0022, smc_bus_pkg::XSIZ_8,  32'h003C_0000, 1'b0);
      add_row(1'b1, 32'h0000_0023, smc_bus_pkg::XSIZ_8,  32'h0, 1'b1);
      add_row(1'b0, 32'h0000_0021, smc_bus_pkg::XSIZ_8,  32'h0, 1'b0);
      add_row(1'b1, 32'h0000_0032, smc_bus_pkg::XSIZ_16, 32'h0, 1'b1);
      add_row(1'b0, 32'h0000_0032, smc_bus_pkg::XSIZ_16, 32'h0, 1'b0);
      add_row(1'b1, 32'h0000_0030, smc_bus_pkg::XSIZ_16, 32'h0000_BEEF, 1'b0);
      add_row(1'b0, 32'h0000_0030, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      add_row(1'b0, 32'h0000_0020, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      // Bank 1, 16-bit bus
      add_row(1'b1, 32'h1000_0040, smc_bus_pkg::XSIZ_32, 32'h0, 1'b1);
      add_row(1'b0, 32'h1000_0040, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      add_row(1'b1, 32'h1000_0052, smc_bus_pkg::XSIZ_16, 32'hCAFE_0000, 1'b0);
      add_row(1'b0, 32'h1000_0052, smc_bus_pkg::XSIZ_16, 32'h0, 1'b0);
      add_row(1'b1, 32'h1000_0063, smc_bus_pkg::XSIZ_8,  32'h0, 1'b1);
      add_row(1'b0, 32'h1000_0063, smc_bus_pkg::XSIZ_8,  32'h0, 1'b0);
      add_row(1'b0, 32'h1000_0060, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      // Bank 2, 8-bit bus
      add_row(1'b1, 32'h2000_0080, smc_bus_pkg::XSIZ_32, 32'h0, 1'b1);
      add_row(1'b0, 32'h2000_0080, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      add_row(1'b1, 32'h2000_0092, smc_bus_pkg::XSIZ_16, 32'h0, 1'b1);
      add_row(1'b0, 32'h2000_0092, smc_bus_pkg::XSIZ_16, 32'h0, 1'b0);
      add_row(1'b1, 32'h2000_00A1, smc_bus_pkg::XSIZ_8,  32'h0000_5A00, 1'b0);
      add_row(1'b0, 32'h2000_00A1, smc_bus_pkg::XSIZ_8,  32'h0, 1'b0);
      add_row(1'b0, 32'h2000_0090, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      // Addresses in no bank
      add_row(1'b0, 32'h3000_0000, smc_bus_pkg::XSIZ_32, 32'h0, 1'b0);
      add_row(1'b1, 32'hF000_0004, smc_bus_pkg::XSIZ_16, 32'h0, 1'b1);

      repeat (3) @(posedge sys_clk30);                 // Reset for 3 cycles
      #10;
      n_sys_reset30 = 1'b1;
      step_cycle();

      // Idle bus after reset
      check_value("emi.n_cs", emi.n_cs, 32'h7);
      check_value("emi.n_be", emi.n_be, 32'hF);
      check_value("emi.n_we", emi.n_we, 32'h1);
      check_value("emi.n_oe", emi.n_oe, 32'h1);
      check_value("busy", busy, 32'h0);
      check_value("rsp_valid", rsp_valid, 32'h0);

      for (int r = 0; r < row_count; r++)
         run_row(r);

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== smc_lite.f ====
design/smc_bus_pkg.sv
design/smc_emi_pkg.sv
design/smc_access_decode.sv
design/smc_state_machine.sv
design/smc_addr_gen.sv
design/smc_data_path.sv
design/smc_lite_top.sv
testbench/emi_memory_model.sv
testbench/smc_lite_tb.sv
